/* src/mgnt_pkg.sv */
package mgnt_pkg;

    //////////////////////////////////////////////////
    // widths and register types
    //////////////////////////////////////////////////

    localparam int REG_WIDTH     = 32;
    localparam int BYTES_PER_REG = REG_WIDTH / 8;

    typedef logic [REG_WIDTH-1:0] mgnt_word_t;
    typedef logic [7:0]           mgnt_addr_t;
    typedef logic [7:0]           mgnt_byte_t;
    typedef logic [1:0]           byte_cnt_t;
    // low field of every frame report
    typedef logic [11:0]          frame_len_t;

    // flag bits sit above the length field
    // rx order is vlan lldp 1588 tte fcs runt jabber bp
    // tx order is vlan fc 1588 tte
    localparam int RX_FLAG_WIDTH = 8;
    localparam int TX_FLAG_WIDTH = 4;
    // errors are the top flag bits of a report
    localparam int RX_ERR_WIDTH  = 4;
    localparam int TX_ERR_WIDTH  = 0;

    //////////////////////////////////////////////////
    // address map
    //////////////////////////////////////////////////

    localparam mgnt_addr_t ADDR_RX_BASE    = 8'h00;
    localparam mgnt_addr_t ADDR_TX_BASE    = 8'h10;
    localparam mgnt_addr_t ADDR_LLDP_ADDR0 = 8'h80;
    localparam mgnt_addr_t ADDR_LLDP_ADDR1 = 8'h81;
    localparam mgnt_addr_t ADDR_LLDP_ADDR2 = 8'h82;
    localparam mgnt_addr_t ADDR_LLDP_PORT  = 8'h83;
    // mode 1 sink, 2 source, 4 compatible
    localparam mgnt_addr_t ADDR_LLDP_MODE  = 8'h84;
    localparam mgnt_addr_t ADDR_LLDP_FUNC  = 8'h8F;

    // counter slots, same in both banks
    localparam int CNT_PKT       = 0;
    localparam int CNT_BYTE      = 1;
    localparam int CNT_FLAG_BASE = 2;

    //////////////////////////////////////////////////
    // bundles between blocks
    //////////////////////////////////////////////////

    typedef struct packed {
        logic       wr_stb;
        logic       rd_stb;
        mgnt_addr_t addr;
    } mgnt_cmd_t;

    typedef struct packed {
        mgnt_addr_t addr;
        mgnt_word_t data;
    } mgnt_wr_t;

    typedef struct packed {
        logic [3:0]  mode;
        logic [3:0]  port;
        logic [47:0] dest;
    } lldp_conf_t;

    typedef enum logic [2:0] {
        CMD_IDLE, CMD_LOAD, CMD_SHIFT,
        CMD_COLLECT, CMD_COMMIT, CMD_ACK
    } cmd_state_e;

    typedef enum logic [1:0] {
        RPT_IDLE, RPT_COUNT, RPT_HOLD
    } rpt_state_e;

    typedef enum logic {
        CONF_IDLE, CONF_BUSY
    } conf_state_e;

endpackage

/* src/mgnt_cmd_decode.sv */
`timescale 1ns/100ps

module mgnt_cmd_decode import mgnt_pkg::*; (
    input  logic       clk_if,
    input  logic       rst_if,
    input  logic       sys_req_valid,
    input  logic       sys_req_wr,
    input  mgnt_addr_t sys_req_addr,
    input  mgnt_byte_t sys_req_data,
    input  logic       sys_req_data_valid,
    // fourth byte leaving the serialiser
    input  logic       rd_last,
    output mgnt_cmd_t  cmd,
    output mgnt_wr_t   wr,
    output logic       sys_req_ack
);

    cmd_state_e state_q;
    cmd_state_e state_nx;
    mgnt_addr_t addr_q;
    mgnt_word_t data_q;
    byte_cnt_t  byte_cnt_q;
    logic       last_byte;

    // last byte of a write word arriving now
    assign last_byte = sys_req_data_valid &&
                       (byte_cnt_q == byte_cnt_t'(BYTES_PER_REG - 1));

    //////////////////////////////////////////////////
    // command sequencer
    //////////////////////////////////////////////////

    always_comb begin
        state_nx = state_q;
        case (state_q)
            CMD_IDLE: begin
                if (sys_req_valid) begin
                    state_nx = sys_req_wr ? CMD_COLLECT : CMD_LOAD;
                end
            end
            // read strobe goes out here
            CMD_LOAD:    state_nx = CMD_SHIFT;
            CMD_SHIFT: begin
                if (rd_last) begin
                    state_nx = CMD_ACK;
                end
            end
            CMD_COLLECT: begin
                if (last_byte) begin
                    state_nx = CMD_COMMIT;
                end
            end
            // single cycle write strobe
            CMD_COMMIT:  state_nx = CMD_ACK;
            CMD_ACK: begin
                if (!sys_req_valid) begin
                    state_nx = CMD_IDLE;
                end
            end
            default:     state_nx = CMD_IDLE;
        endcase
    end

    always_ff @(posedge clk_if) begin
        if (!rst_if) begin
            state_q     <= CMD_IDLE;
            byte_cnt_q  <= '0;
            sys_req_ack <= 1'b0;
        end else begin
            state_q     <= state_nx;
            // ack tracks the ack state, one flop deep
            sys_req_ack <= (state_nx == CMD_ACK);
            if (state_q == CMD_IDLE) begin
                byte_cnt_q <= '0;
            end else if (state_q == CMD_COLLECT && sys_req_data_valid) begin
                byte_cnt_q <= byte_cnt_q + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // address latch and write gatherer
    //////////////////////////////////////////////////

    always_ff @(posedge clk_if) begin
        // addr and wr sampled with valid in idle only
        if (state_q == CMD_IDLE && sys_req_valid) begin
            addr_q <= sys_req_addr;
        end
        // msb arrives first
        if (state_q == CMD_COLLECT && sys_req_data_valid) begin
            data_q <= {data_q[REG_WIDTH-$bits(mgnt_byte_t)-1:0], sys_req_data};
        end
    end

    assign cmd.wr_stb = (state_q == CMD_COMMIT);
    assign cmd.rd_stb = (state_q == CMD_LOAD);
    assign cmd.addr   = addr_q;
    assign wr.addr    = addr_q;
    assign wr.data    = data_q;

    // one command type at a time
    a_strobe_excl: assert property (@(posedge clk_if) disable iff (!rst_if)
        !(cmd.rd_stb && cmd.wr_stb));

endmodule

/* src/stat_bank.sv */
`timescale 1ns/100ps

module stat_bank import mgnt_pkg::*; #(
    parameter int FLAG_WIDTH = RX_FLAG_WIDTH,
    parameter int ERR_WIDTH  = RX_ERR_WIDTH
) (
    input  logic                                    clk_if,
    input  logic                                    rst_if,
    input  logic                                    rpt_valid,
    input  logic [$bits(frame_len_t)+FLAG_WIDTH-1:0] rpt_data,
    input  mgnt_addr_t                              rd_addr,
    output logic                                    rpt_resp,
    output mgnt_word_t                              rd_data
);

    localparam int NUM_CNT = CNT_FLAG_BASE + FLAG_WIDTH;
    // top ERR_WIDTH flag bits
    localparam logic [FLAG_WIDTH-1:0] ERR_MASK = ~({FLAG_WIDTH{1'b1}} >> ERR_WIDTH);

    logic [1:0]                              valid_sync;
    logic [$bits(frame_len_t)+FLAG_WIDTH-1:0] rpt_q;
    rpt_state_e                              state_q;
    rpt_state_e                              state_nx;
    frame_len_t                              rpt_len;
    logic [FLAG_WIDTH-1:0]                   rpt_flags;
    logic                                    rpt_err;
    mgnt_word_t                              cnt [NUM_CNT];

    //////////////////////////////////////////////////
    // report capture
    //////////////////////////////////////////////////

    always_ff @(posedge clk_if) begin
        if (!rst_if) begin
            valid_sync <= '0;
        end else begin
            valid_sync <= {valid_sync[0], rpt_valid};
        end
    end

    // source holds data until resp, so two high stages mean stable
    always_ff @(posedge clk_if) begin
        if (valid_sync == 2'b11) begin
            rpt_q <= rpt_data;
        end
    end

    assign rpt_len   = rpt_q[$bits(frame_len_t)-1:0];
    assign rpt_flags = rpt_q[$bits(frame_len_t) +: FLAG_WIDTH];
    assign rpt_err   = |(rpt_flags & ERR_MASK);

    // report fsm
    always_comb begin
        state_nx = state_q;
        case (state_q)
            RPT_IDLE:  state_nx = valid_sync[1] ? RPT_COUNT : RPT_IDLE;
            RPT_COUNT: state_nx = RPT_HOLD;
            // wait for the source to drop valid
            RPT_HOLD:  state_nx = valid_sync[1] ? RPT_HOLD : RPT_IDLE;
            default:   state_nx = RPT_IDLE;
        endcase
    end

    always_ff @(posedge clk_if) begin
        if (!rst_if) begin
            state_q  <= RPT_IDLE;
            rpt_resp <= 1'b0;
        end else begin
            state_q  <= state_nx;
            rpt_resp <= (state_q == RPT_HOLD);
        end
    end

    //////////////////////////////////////////////////
    // counter array
    //////////////////////////////////////////////////

    always_ff @(posedge clk_if) begin
        if (!rst_if) begin
            for (int i = 0; i < NUM_CNT; i++) begin
                cnt[i] <= '0;
            end
        end else if (state_q == RPT_COUNT) begin
            // errored frames skip pkt and byte totals
            if (!rpt_err) begin
                cnt[CNT_PKT]  <= cnt[CNT_PKT] + 1'b1;
                cnt[CNT_BYTE] <= cnt[CNT_BYTE] + mgnt_word_t'(rpt_len);
            end
            // each flag has its own slot, errors too
            for (int k = 0; k < FLAG_WIDTH; k++) begin
                if (rpt_flags[k]) begin
                    cnt[CNT_FLAG_BASE+k] <= cnt[CNT_FLAG_BASE+k] + 1'b1;
                end
            end
        end
    end

    // low nibble picks the slot, unused slots read zero
    always_comb begin
        rd_data = '0;
        for (int i = 0; i < NUM_CNT; i++) begin
            if (rd_addr[3:0] == i[3:0]) begin
                rd_data = cnt[i];
            end
        end
    end

    // count cycle leads straight into hold and resp
    a_count_hold: assert property (@(posedge clk_if) disable iff (!rst_if)
        state_q == RPT_COUNT |=> state_q == RPT_HOLD ##1 rpt_resp);

endmodule

/* src/lldp_conf_regs.sv */
`timescale 1ns/100ps

module lldp_conf_regs import mgnt_pkg::*; (
    input  logic       clk_if,
    input  logic       rst_if,
    input  mgnt_wr_t   wr,
    input  mgnt_cmd_t  cmd,
    input  logic       conf_resp,
    output logic       conf_valid,
    output lldp_conf_t conf_data,
    output mgnt_word_t rd_data
);

    mgnt_word_t  addr0_q;
    mgnt_word_t  addr1_q;
    mgnt_word_t  addr2_q;
    mgnt_word_t  port_q;
    mgnt_word_t  mode_q;
    logic [1:0]  resp_sync;
    logic        func_hit;
    conf_state_e state_q;
    conf_state_e state_nx;

    //////////////////////////////////////////////////
    // register file
    //////////////////////////////////////////////////

    always_ff @(posedge clk_if) begin
        if (!rst_if) begin
            addr0_q <= '0;
            addr1_q <= '0;
            addr2_q <= '0;
            port_q  <= '0;
            mode_q  <= '0;
        end else if (cmd.wr_stb) begin
            case (wr.addr)
                ADDR_LLDP_ADDR0: addr0_q <= wr.data;
                ADDR_LLDP_ADDR1: addr1_q <= wr.data;
                ADDR_LLDP_ADDR2: addr2_q <= wr.data;
                ADDR_LLDP_PORT:  port_q  <= wr.data;
                ADDR_LLDP_MODE:  mode_q  <= wr.data;
                default: ;
            endcase
        end
    end

    // read back, func address and holes read zero
    always_comb begin
        case (cmd.addr)
            ADDR_LLDP_ADDR0: rd_data = addr0_q;
            ADDR_LLDP_ADDR1: rd_data = addr1_q;
            ADDR_LLDP_ADDR2: rd_data = addr2_q;
            ADDR_LLDP_PORT:  rd_data = port_q;
            ADDR_LLDP_MODE:  rd_data = mode_q;
            default:         rd_data = '0;
        endcase
    end

    // dest mac is 16 bits from each address word, word 2 on top
    assign conf_data.mode = mode_q[3:0];
    assign conf_data.port = port_q[3:0];
    assign conf_data.dest = {addr2_q[15:0], addr1_q[15:0], addr0_q[15:0]};

    //////////////////////////////////////////////////
    // conf transfer to rx path
    //////////////////////////////////////////////////

    assign func_hit = cmd.wr_stb && (wr.addr == ADDR_LLDP_FUNC);

    always_comb begin
        state_nx = state_q;
        case (state_q)
            CONF_IDLE: state_nx = func_hit ? CONF_BUSY : CONF_IDLE;
            // rx side answers across the clock boundary
            CONF_BUSY: state_nx = resp_sync[1] ? CONF_IDLE : CONF_BUSY;
            default:   state_nx = CONF_IDLE;
        endcase
    end

    always_ff @(posedge clk_if) begin
        if (!rst_if) begin
            resp_sync  <= '0;
            state_q    <= CONF_IDLE;
            conf_valid <= 1'b0;
        end else begin
            resp_sync  <= {resp_sync[0], conf_resp};
            state_q    <= state_nx;
            conf_valid <= (state_q == CONF_BUSY);
        end
    end

endmodule

/* src/mgnt_read_serializer.sv */
`timescale 1ns/100ps

module mgnt_read_serializer import mgnt_pkg::*; (
    input  logic       clk_if,
    input  logic       rst_if,
    input  mgnt_cmd_t  cmd,
    input  mgnt_word_t rx_rd_data,
    input  mgnt_word_t tx_rd_data,
    input  mgnt_word_t lldp_rd_data,
    output mgnt_byte_t sys_resp_data,
    output logic       sys_resp_data_valid,
    output logic       rd_last
);

    mgnt_word_t sel_word;
    mgnt_word_t shift_q;
    byte_cnt_t  cnt_q;

    //////////////////////////////////////////////////
    // word select
    //////////////////////////////////////////////////

    // bit 7 picks lldp, then the nibble picks rx or tx
    always_comb begin
        if (cmd.addr[7]) begin
            sel_word = lldp_rd_data;
        end else if (cmd.addr[7:4] == ADDR_TX_BASE[7:4]) begin
            sel_word = tx_rd_data;
        end else if (cmd.addr[7:4] == ADDR_RX_BASE[7:4]) begin
            sel_word = rx_rd_data;
        end else begin
            sel_word = '0;
        end
    end

    // byte shifter, msb first
    always_ff @(posedge clk_if) begin
        if (!rst_if) begin
            sys_resp_data_valid <= 1'b0;
            cnt_q               <= '0;
        end else if (cmd.rd_stb) begin
            sys_resp_data_valid <= 1'b1;
            cnt_q               <= '0;
        end else if (sys_resp_data_valid) begin
            cnt_q <= cnt_q + 1'b1;
            if (rd_last) begin
                sys_resp_data_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_if) begin
        if (cmd.rd_stb) begin
            shift_q <= sel_word;
        end else if (sys_resp_data_valid) begin
            shift_q <= shift_q << $bits(mgnt_byte_t);
        end
    end

    assign sys_resp_data = shift_q[REG_WIDTH-1 -: $bits(mgnt_byte_t)];
    assign rd_last       = sys_resp_data_valid &&
                           (cnt_q == byte_cnt_t'(BYTES_PER_REG - 1));

    // decode must not reload a word still going out
    a_no_reload: assert property (@(posedge clk_if) disable iff (!rst_if)
        cmd.rd_stb |-> !sys_resp_data_valid);

endmodule

/* src/mac_ctrl_top.sv */
`timescale 1ns/100ps

module mac_ctrl_top import mgnt_pkg::*; #(
    parameter int RX_FLAGS = RX_FLAG_WIDTH,
    parameter int RX_ERRS  = RX_ERR_WIDTH,
    parameter int TX_FLAGS = TX_FLAG_WIDTH,
    parameter int TX_ERRS  = TX_ERR_WIDTH
) (
    input  logic                                  clk_if,
    input  logic                                  rst_if,
    // rx report channel
    input  logic                                  rx_mgnt_valid,
    input  logic [$bits(frame_len_t)+RX_FLAGS-1:0] rx_mgnt_data,
    output logic                                  rx_mgnt_resp,
    // tx report channel
    input  logic                                  tx_mgnt_valid,
    input  logic [$bits(frame_len_t)+TX_FLAGS-1:0] tx_mgnt_data,
    output logic                                  tx_mgnt_resp,
    // lldp conf toward rx path
    output logic                                  rx_conf_valid,
    output lldp_conf_t                            rx_conf_data,
    input  logic                                  rx_conf_resp,
    // system side
    input  logic                                  sys_req_valid,
    input  logic                                  sys_req_wr,
    input  mgnt_addr_t                            sys_req_addr,
    input  mgnt_byte_t                            sys_req_data,
    input  logic                                  sys_req_data_valid,
    output logic                                  sys_req_ack,
    output mgnt_byte_t                            sys_resp_data,
    output logic                                  sys_resp_data_valid
);

    mgnt_cmd_t  cmd;
    mgnt_wr_t   wr;
    mgnt_word_t rx_rd_data;
    mgnt_word_t tx_rd_data;
    mgnt_word_t lldp_rd_data;
    logic       rd_last;

    //////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////

    mgnt_cmd_decode u_cmd_decode (
        .clk_if             (clk_if),
        .rst_if             (rst_if),
        .sys_req_valid      (sys_req_valid),
        .sys_req_wr         (sys_req_wr),
        .sys_req_addr       (sys_req_addr),
        .sys_req_data       (sys_req_data),
        .sys_req_data_valid (sys_req_data_valid),
        .rd_last            (rd_last),
        .cmd                (cmd),
        .wr                 (wr),
        .sys_req_ack        (sys_req_ack)
    );

    //////////////////////////////////////////////////
    // execute
    //////////////////////////////////////////////////

    stat_bank #(
        .FLAG_WIDTH (RX_FLAGS),
        .ERR_WIDTH  (RX_ERRS)
    ) u_rx_stat (
        .clk_if    (clk_if),
        .rst_if    (rst_if),
        .rpt_valid (rx_mgnt_valid),
        .rpt_data  (rx_mgnt_data),
        .rd_addr   (cmd.addr),
        .rpt_resp  (rx_mgnt_resp),
        .rd_data   (rx_rd_data)
    );

    stat_bank #(
        .FLAG_WIDTH (TX_FLAGS),
        .ERR_WIDTH  (TX_ERRS)
    ) u_tx_stat (
        .clk_if    (clk_if),
        .rst_if    (rst_if),
        .rpt_valid (tx_mgnt_valid),
        .rpt_data  (tx_mgnt_data),
        .rd_addr   (cmd.addr),
        .rpt_resp  (tx_mgnt_resp),
        .rd_data   (tx_rd_data)
    );

    lldp_conf_regs u_lldp_conf (
        .clk_if     (clk_if),
        .rst_if     (rst_if),
        .wr         (wr),
        .cmd        (cmd),
        .conf_resp  (rx_conf_resp),
        .conf_valid (rx_conf_valid),
        .conf_data  (rx_conf_data),
        .rd_data    (lldp_rd_data)
    );

    // result path
    mgnt_read_serializer u_read_ser (
        .clk_if              (clk_if),
        .rst_if              (rst_if),
        .cmd                 (cmd),
        .rx_rd_data          (rx_rd_data),
        .tx_rd_data          (tx_rd_data),
        .lldp_rd_data        (lldp_rd_data),
        .sys_resp_data       (sys_resp_data),
        .sys_resp_data_valid (sys_resp_data_valid),
        .rd_last             (rd_last)
    );

endmodule

/* dv/tb_mac_ctrl_tasks.svh */
`ifndef TB_MAC_CTRL_TASKS_SVH
`define TB_MAC_CTRL_TASKS_SVH

//////////////////////////////////////////////////
// stop and compare
//////////////////////////////////////////////////

task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at first error");
endtask

task automatic check_word(input mgnt_word_t got, input mgnt_word_t exp_word,
                          input string what);
    if (got !== exp_word) begin
        abort_run($sformatf("FAIL %0t: %s gave %h, expected %h", $time, what, got, exp_word));
    end
endtask

task automatic check_conf(input lldp_conf_t got, input lldp_conf_t exp_conf);
    if (got !== exp_conf) begin
        abort_run($sformatf("FAIL %0t: rx_conf_data is %h, expected %h",
                            $time, got, exp_conf));
    end
endtask

task automatic check_resp_byte(input mgnt_byte_t got, input mgnt_byte_t exp_byte,
                               input string what);
    if (got !== exp_byte) begin
        abort_run($sformatf("FAIL %0t: %s is %h, expected %h", $time, what, got, exp_byte));
    end
endtask

task automatic check_level(input logic got, input logic exp_lvl, input string what);
    if (got !== exp_lvl) begin
        abort_run($sformatf("FAIL %0t: %s is %b, expected %b", $time, what, got, exp_lvl));
    end
endtask

function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// 0 to 3 idle cycles between ops
task automatic idle_gap();
    int gap;
    rng_state = xorshift32(rng_state);
    gap = int'(rng_state[1:0]);
    repeat (gap) @(posedge clk_if);
endtask

//////////////////////////////////////////////////
// report channels
//////////////////////////////////////////////////

task automatic send_report(input bit to_tx, input logic [19:0] value);
    logic resp;
    check_level(to_tx ? tx_mgnt_resp : rx_mgnt_resp, 1'b0, "resp before report");
    @(posedge clk_if);
    if (to_tx) begin
        tx_mgnt_valid <= 1'b1;
        tx_mgnt_data  <= value[15:0];
    end else begin
        rx_mgnt_valid <= 1'b1;
        rx_mgnt_data  <= value;
    end
    // data held until the bank answers
    resp = 1'b0;
    while (!resp) begin
        @(negedge clk_if);
        resp = to_tx ? tx_mgnt_resp : rx_mgnt_resp;
    end
    @(posedge clk_if);
    rx_mgnt_valid <= 1'b0;
    tx_mgnt_valid <= 1'b0;
    // resp holds until the bank sees valid low
    @(negedge clk_if);
    resp = to_tx ? tx_mgnt_resp : rx_mgnt_resp;
    check_level(resp, 1'b1, "resp before the valid drop was seen");
    while (resp) begin
        @(negedge clk_if);
        resp = to_tx ? tx_mgnt_resp : rx_mgnt_resp;
    end
endtask

//////////////////////////////////////////////////
// system register port
//////////////////////////////////////////////////

// wait for ack, then release the request and see ack fall
task automatic finish_request();
    while (!sys_req_ack) begin
        @(negedge clk_if);
    end
    @(posedge clk_if);
    sys_req_valid <= 1'b0;
    sys_req_wr    <= 1'b0;
    // ack holds until the sequencer sees valid low
    @(negedge clk_if);
    check_level(sys_req_ack, 1'b1, "sys_req_ack before the valid drop was seen");
    while (sys_req_ack) begin
        @(negedge clk_if);
    end
endtask

task automatic write_reg(input mgnt_addr_t addr, input mgnt_word_t data);
    @(posedge clk_if);
    sys_req_valid <= 1'b1;
    sys_req_wr    <= 1'b1;
    sys_req_addr  <= addr;
    // msb first and one byte a cycle once the sequencer collects
    for (int i = BYTES_PER_REG - 1; i >= 0; i--) begin
        @(posedge clk_if);
        sys_req_data       <= data[i*8 +: 8];
        sys_req_data_valid <= 1'b1;
        @(negedge clk_if);
        check_level(sys_req_ack, 1'b0, "sys_req_ack during write bytes");
    end
    @(posedge clk_if);
    sys_req_data_valid <= 1'b0;
    // ack stays low through the commit cycle
    @(negedge clk_if);
    check_level(sys_req_ack, 1'b0, "sys_req_ack in the commit cycle");
    finish_request();
endtask

task automatic read_reg(input mgnt_addr_t addr, input mgnt_word_t exp_word);
    mgnt_word_t word;
    int         nbytes;
    word   = '0;
    nbytes = 0;
    @(posedge clk_if);
    sys_req_valid <= 1'b1;
    sys_req_wr    <= 1'b0;
    sys_req_addr  <= addr;
    while (nbytes < BYTES_PER_REG) begin
        @(negedge clk_if);
        check_level(sys_req_ack, 1'b0, "sys_req_ack during read bytes");
        if (sys_resp_data_valid) begin
            // first byte out is the top byte of the word
            if (nbytes == 0) begin
                check_resp_byte(sys_resp_data, exp_word[REG_WIDTH-1 -: 8],
                                $sformatf("first byte of read at %h", addr));
            end
            word = {word[23:0], sys_resp_data};
            nbytes++;
        end
    end
    // exactly four bytes per read
    @(negedge clk_if);
    check_level(sys_resp_data_valid, 1'b0, "sys_resp_data_valid after fourth byte");
    check_word(word, exp_word, $sformatf("read at %h", addr));
    finish_request();
endtask

// wait for conf valid, answer it and see it drop
task automatic conf_transfer(input lldp_conf_t exp_conf);
    while (!rx_conf_valid) begin
        @(negedge clk_if);
    end
    check_conf(rx_conf_data, exp_conf);
    @(posedge clk_if);
    rx_conf_resp <= 1'b1;
    while (rx_conf_valid) begin
        @(negedge clk_if);
    end
    @(posedge clk_if);
    rx_conf_resp <= 1'b0;
endtask

`endif

/* dv/tb_mac_ctrl.sv */
`timescale 1ns/100ps

module tb_mac_ctrl import mgnt_pkg::*; ();

    // op codes of the input file
    localparam int OP_RX_RPT    = 0;
    localparam int OP_TX_RPT    = 1;
    localparam int OP_WRITE     = 2;
    localparam int OP_READ      = 3;
    localparam int OP_LLDP_FUNC = 4;
    // worst op plus the largest idle gap fits well inside this
    localparam int CYCLES_PER_OP = 40;
    localparam int RESET_CYCLES  = 2;
    localparam logic [31:0] SEED = 32'h1472;

    typedef struct packed {
        logic [7:0]  code;
        logic [31:0] arg;
        mgnt_word_t  data;
        logic [63:0] exp_val;
    } op_t;

    logic clk_if = 1'b0;
    logic rst_if;
    logic rx_mgnt_valid;
    logic [$bits(frame_len_t)+RX_FLAG_WIDTH-1:0] rx_mgnt_data;
    logic rx_mgnt_resp;
    logic tx_mgnt_valid;
    logic [$bits(frame_len_t)+TX_FLAG_WIDTH-1:0] tx_mgnt_data;
    logic tx_mgnt_resp;
    logic rx_conf_valid;
    lldp_conf_t rx_conf_data;
    logic rx_conf_resp;
    logic sys_req_valid;
    logic sys_req_wr;
    mgnt_addr_t sys_req_addr;
    mgnt_byte_t sys_req_data;
    logic sys_req_data_valid;
    logic sys_req_ack;
    mgnt_byte_t sys_resp_data;
    logic sys_resp_data_valid;

    op_t         ops[$];
    logic [31:0] rng_state = SEED;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;

    `include "tb_mac_ctrl_tasks.svh"

    mac_ctrl_top dut (.*);

    always #50 clk_if = ~clk_if;

    // run limit, armed once the op list is known
    always @(posedge clk_if) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            abort_run($sformatf("timeout, run still busy after %0d clock cycles",
                                cycle_limit));
        end
    end

    //////////////////////////////////////////////////
    // op list and main sequence
    //////////////////////////////////////////////////

    initial begin
        int          fd;
        int          n;
        string       line;
        logic [7:0]  code;
        logic [31:0] arg;
        mgnt_word_t  data;
        logic [63:0] exp_val;

        rst_if             = 1'b0;
        rx_mgnt_valid      = 1'b0;
        rx_mgnt_data       = '0;
        tx_mgnt_valid      = 1'b0;
        tx_mgnt_data       = '0;
        rx_conf_resp       = 1'b0;
        sys_req_valid      = 1'b0;
        sys_req_wr         = 1'b0;
        sys_req_addr       = '0;
        sys_req_data       = '0;
        sys_req_data_valid = 1'b0;

        fd = $fopen("dv/mgnt_input.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open dv/mgnt_input.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // skip blank and comment lines
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h", code, arg, data, exp_val);
            if (n == 4) begin
                ops.push_back({code, arg, data, exp_val});
            end
        end
        $fclose(fd);
        if (ops.size() == 0) begin
            abort_run("input file holds no ops");
        end
        cycle_limit = (ops.size() + RESET_CYCLES) * CYCLES_PER_OP;

        repeat (RESET_CYCLES) @(posedge clk_if);
        rst_if <= 1'b1;
        // outputs idle out of reset
        @(negedge clk_if);
        check_level(rx_mgnt_resp, 1'b0, "rx_mgnt_resp after reset");
        check_level(tx_mgnt_resp, 1'b0, "tx_mgnt_resp after reset");
        check_level(rx_conf_valid, 1'b0, "rx_conf_valid after reset");
        check_level(sys_req_ack, 1'b0, "sys_req_ack after reset");
        check_level(sys_resp_data_valid, 1'b0, "sys_resp_data_valid after reset");

        foreach (ops[i]) begin
            idle_gap();
            case (int'(ops[i].code))
                OP_RX_RPT: send_report(1'b0, ops[i].arg[19:0]);
                OP_TX_RPT: send_report(1'b1, ops[i].arg[19:0]);
                OP_WRITE:  write_reg(mgnt_addr_t'(ops[i].arg), ops[i].data);
                OP_READ:   read_reg(mgnt_addr_t'(ops[i].arg), ops[i].exp_val[31:0]);
                OP_LLDP_FUNC: begin
                    check_level(rx_conf_valid, 1'b0, "rx_conf_valid before trigger");
                    write_reg(mgnt_addr_t'(ops[i].arg), ops[i].data);
                    conf_transfer(lldp_conf_t'(ops[i].exp_val[55:0]));
                end
                default: begin
                    abort_run($sformatf("unknown op code %h in input file", ops[i].code));
                end
            endcase
        end

        repeat (2) @(posedge clk_if);
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* sim.f */
src/mgnt_pkg.sv
src/mgnt_cmd_decode.sv
src/stat_bank.sv
src/lldp_conf_regs.sv
src/mgnt_read_serializer.sv
src/mac_ctrl_top.sv
+incdir+dv
dv/tb_mac_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with verilator, run it, decide by the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -f "$LOG"
verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module tb_mac_ctrl -Mdir "$OBJ" -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
    exit 0
fi
echo "pass message missing from $LOG"
exit 1

/* dv/mgnt_input.txt */
# columns, all hex: op arg data expected
# op 0 rx report, 1 tx report, 2 write, 3 read, 4 lldp function write
0 00000040 00000000 0
0 000015EE 00000000 0
0 0001303C 00000000 0
0 0008A100 00000000 0
0 00006200 00000000 0
3 00000000 00000000 00000003
3 00000001 00000000 0000082E
3 00000002 00000000 00000002
3 00000003 00000000 00000003
3 00000005 00000000 00000001
3 00000006 00000000 00000001
3 00000009 00000000 00000001
3 0000000A 00000000 00000000
1 000015DC 00000000 0
1 0000E040 00000000 0
1 00008123 00000000 0
3 00000010 00000000 00000003
3 00000011 00000000 0000073F
3 00000012 00000000 00000001
3 00000015 00000000 00000002
2 00000080 1234A1B2 0
2 00000081 0000C3D4 0
2 00000082 FFFFE5F6 0
2 00000083 00000007 0
2 00000084 00000002 0
3 00000080 00000000 1234A1B2
3 00000081 00000000 0000C3D4
3 00000082 00000000 FFFFE5F6
3 00000083 00000000 00000007
3 00000084 00000000 00000002
3 00000040 00000000 00000000
4 0000008F 00000000 0027E5F6C3D4A1B2
3 0000008F 00000000 00000000
